//--- logic/uop_pkg.sv
package uop_pkg;

    // reorder buffer sizing
    localparam int rob_depth = 8;
    localparam int rob_idx_w = 3;
    // tag is entry index plus one slot bit
    localparam int rob_tag_w = rob_idx_w + 1;

    // upper bits select the entry, bit 0 selects the slot
    typedef logic [rob_tag_w-1:0] rob_tag_t;

    // one decoded micro-op as seen by retirement
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        // set when this op sits in the delay slot of a branch
        logic        is_delay_slot;
        logic [4:0]  dest;
    } uop_t;

    // slot0 is the older op of the pair
    typedef struct packed {
        uop_t slot1;
        uop_t slot0;
    } uop_pair_t;

endpackage

//--- logic/fu_pkg.sv
package fu_pkg;

    // MIPS cause register ExcCode values
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ov   = 5'd12
    } exc_code_t;

    // meaning depends on which flag came with the report
    typedef union packed {
        logic [31:0] branch_target;
        logic [31:0] bad_vaddr;
    } aux_word_u;

    // completion report from a functional unit
    typedef struct packed {
        logic              finish;
        uop_pkg::rob_tag_t tag;
        logic              set_branch;
        logic              branch_taken;
        logic              set_exception;
        exc_code_t         exc_code;
        aux_word_u         aux;
    } fu_report_t;

    // one slot of a reorder buffer entry
    typedef struct packed {
        uop_pkg::uop_t uop;
        logic          busy;
        logic          committed;
        logic          branch_taken;
        logic          cause_exc;
        exc_code_t     exc_code;
        aux_word_u     aux;
    } rob_slot_t;

    typedef struct packed {
        rob_slot_t slot1;
        rob_slot_t slot0;
        logic      slot1_retire;
        logic      slot0_retire;
    } retire_t;

endpackage

//--- logic/dispatch_stage.sv
module dispatch_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               flush,

    // front end side
    input  logic               in_valid,
    input  uop_pkg::uop_pair_t in_pair,
    output logic               in_ready,

    // reorder buffer side
    output logic               disp_valid,
    output uop_pkg::uop_pair_t disp_pair,
    input  logic               disp_ready
);

    logic pair_has_uop;
    logic in_fire;

    // a bundle with no valid slot is swallowed here
    assign pair_has_uop = in_pair.slot0.valid || in_pair.slot1.valid;

    // register frees up in the same cycle the buffer takes it;
    // nothing is taken while the pipe is being flushed
    assign in_ready = !flush && (!disp_valid || disp_ready);
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            disp_valid <= 1'b0;
        end else if (flush) begin
            disp_valid <= 1'b0;
        end else if (in_ready) begin
            disp_valid <= in_valid && pair_has_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            disp_pair <= in_pair;
        end
    end

endmodule

//--- logic/reorder_buffer.sv
module reorder_buffer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               flush,

    // dispatch side
    input  logic               disp_valid,
    input  uop_pkg::uop_pair_t disp_pair,
    output logic               disp_ready,

    // completion ports
    input  fu_pkg::fu_report_t alu_report,
    input  fu_pkg::fu_report_t lsu_report,

    // commit side
    output logic               commit_valid,
    output fu_pkg::retire_t    commit_rec,
    input  logic               commit_ready
);

    // pointers carry one extra wrap bit above the index
    logic [uop_pkg::rob_idx_w:0]   head_ptr;
    logic [uop_pkg::rob_idx_w:0]   tail_ptr;
    logic [uop_pkg::rob_idx_w-1:0] head_idx;
    logic [uop_pkg::rob_idx_w-1:0] tail_idx;
    logic [uop_pkg::rob_idx_w:0]   used;
    logic                          empty;
    logic                          full;

    logic disp_fire;
    logic commit_fire;
    logic ok0;
    logic ok1;
    logic done0;
    logic done1;

    fu_pkg::rob_slot_t  mem [uop_pkg::rob_depth][2];
    fu_pkg::rob_slot_t  head0;
    fu_pkg::rob_slot_t  head1;
    uop_pkg::uop_t      disp_uops [2];
    fu_pkg::fu_report_t reports [2];

    assign head_idx = head_ptr[uop_pkg::rob_idx_w-1:0];
    assign tail_idx = tail_ptr[uop_pkg::rob_idx_w-1:0];
    assign used     = tail_ptr - head_ptr;

    assign empty = head_ptr == tail_ptr;
    assign full  = (head_idx == tail_idx) &&
                   (head_ptr[uop_pkg::rob_idx_w] != tail_ptr[uop_pkg::rob_idx_w]);

    // keep one entry spare, as the front end reacts a cycle late
    assign disp_ready = used < uop_pkg::rob_depth - 1;
    assign disp_fire  = disp_valid && disp_ready && !flush;

    assign disp_uops[0] = disp_pair.slot0;
    assign disp_uops[1] = disp_pair.slot1;
    assign reports[0]   = alu_report;
    assign reports[1]   = lsu_report;

    assign head0 = mem[head_idx][0];
    assign head1 = mem[head_idx][1];

    // slot0 waits for its delay slot so a branch never retires alone
    assign ok0 = head0.uop.valid && !head0.committed && !head0.busy &&
                 (!head1.uop.is_delay_slot || !head1.busy);
    // slot1 only goes with or after slot0, and never behind an exception
    assign ok1 = head1.uop.valid && !head1.committed && !head1.busy &&
                 (!head0.uop.valid || head0.committed || (ok0 && !head0.cause_exc));

    assign commit_valid = (ok0 || ok1) && !empty;
    assign commit_fire  = commit_valid && commit_ready;

    assign commit_rec.slot0        = head0;
    assign commit_rec.slot1        = head1;
    assign commit_rec.slot0_retire = ok0;
    assign commit_rec.slot1_retire = ok1;

    // a slot is finished with once it is empty, retired, or retiring now
    assign done0 = !head0.uop.valid || head0.committed || (ok0 && commit_fire);
    assign done1 = !head1.uop.valid || head1.committed || (ok1 && commit_fire);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_ptr <= '0;
        end else if (flush) begin
            tail_ptr <= '0;
        end else if (disp_fire) begin
            tail_ptr <= tail_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
        end else if (flush) begin
            head_ptr <= '0;
        end else if (done0 && done1 && !empty) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

    // entry storage; stale entries past the tail are never looked at
    always_ff @(posedge clk) begin
        if (disp_fire) begin
            for (int s = 0; s < 2; s++) begin
                mem[tail_idx][s].uop          <= disp_uops[s];
                mem[tail_idx][s].busy         <= disp_uops[s].valid;
                mem[tail_idx][s].committed    <= 1'b0;
                mem[tail_idx][s].branch_taken <= 1'b0;
                mem[tail_idx][s].cause_exc    <= 1'b0;
                mem[tail_idx][s].exc_code     <= fu_pkg::exc_none;
                mem[tail_idx][s].aux          <= '0;
            end
        end

        // completion, tag bit 0 picks the slot
        for (int p = 0; p < 2; p++) begin
            if (reports[p].finish) begin
                mem[reports[p].tag[uop_pkg::rob_tag_w-1:1]][reports[p].tag[0]].busy <= 1'b0;
                if (reports[p].set_branch) begin
                    mem[reports[p].tag[uop_pkg::rob_tag_w-1:1]][reports[p].tag[0]].branch_taken
                        <= reports[p].branch_taken;
                    mem[reports[p].tag[uop_pkg::rob_tag_w-1:1]][reports[p].tag[0]].aux
                        <= reports[p].aux;
                end
                if (reports[p].set_exception) begin
                    mem[reports[p].tag[uop_pkg::rob_tag_w-1:1]][reports[p].tag[0]].cause_exc
                        <= 1'b1;
                    mem[reports[p].tag[uop_pkg::rob_tag_w-1:1]][reports[p].tag[0]].exc_code
                        <= reports[p].exc_code;
                    mem[reports[p].tag[uop_pkg::rob_tag_w-1:1]][reports[p].tag[0]].aux
                        <= reports[p].aux;
                end
            end
        end

        if (commit_fire && ok0) begin
            mem[head_idx][0].committed <= 1'b1;
        end
        if (commit_fire && ok1) begin
            mem[head_idx][1].committed <= 1'b1;
        end
    end

    // the spare entry is never filled
    a_no_disp_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        disp_valid && disp_ready |=> !full
    );

    // units only report ops still in flight
    a_report_busy: assert property (
        @(posedge clk) disable iff (!arst_n || flush)
        alu_report.finish |->
            mem[alu_report.tag[uop_pkg::rob_tag_w-1:1]][alu_report.tag[0]].busy
    );

    a_lsu_report_busy: assert property (
        @(posedge clk) disable iff (!arst_n || flush)
        lsu_report.finish |->
            mem[lsu_report.tag[uop_pkg::rob_tag_w-1:1]][lsu_report.tag[0]].busy
    );

    a_no_commit_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        commit_valid |-> used != '0
    );

endmodule

//--- logic/commit_stage.sv
module commit_stage (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              commit_valid,
    input  fu_pkg::retire_t   commit_rec,
    output logic              commit_ready,

    output logic              flush,
    output logic              retire_valid,
    output fu_pkg::retire_t   retire_rec,

    // exception report, valid with flush
    output logic              exc_valid,
    output fu_pkg::exc_code_t exc_code,
    output logic [31:0]       exc_pc,
    output logic [31:0]       bad_vaddr,
    output logic [15:0]       retired_count
);

    logic              commit_fire;
    logic              exc0;
    logic              exc1;
    logic [1:0]        n_retire;
    fu_pkg::rob_slot_t exc_slot;

    // hold off commits while the flush is going out
    assign commit_ready = !flush;
    assign commit_fire  = commit_valid && commit_ready;

    assign exc0 = commit_rec.slot0_retire && commit_rec.slot0.cause_exc;
    assign exc1 = commit_rec.slot1_retire && commit_rec.slot1.cause_exc;

    // slot0 is older, so it wins if both somehow fault
    assign exc_slot = exc0 ? commit_rec.slot0 : commit_rec.slot1;

    assign n_retire = {1'b0, commit_rec.slot0_retire} + {1'b0, commit_rec.slot1_retire};

    assign exc_valid = flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid  <= 1'b0;
            flush         <= 1'b0;
            retired_count <= '0;
        end else begin
            retire_valid <= commit_fire;
            flush        <= commit_fire && (exc0 || exc1);
            if (commit_fire) begin
                retired_count <= retired_count + 16'(n_retire);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit_fire) begin
            retire_rec <= commit_rec;
        end
        if (commit_fire && (exc0 || exc1)) begin
            exc_code  <= exc_slot.exc_code;
            exc_pc    <= exc_slot.uop.pc;
            bad_vaddr <= exc_slot.aux.bad_vaddr;
        end
    end

    // flush is a single pulse
    a_flush_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        flush |=> !flush
    );

endmodule

//--- logic/rob_top.sv
module rob_top (
    input  logic               clk,
    input  logic               arst_n,

    input  logic               in_valid,
    input  uop_pkg::uop_pair_t in_pair,
    output logic               in_ready,

    input  fu_pkg::fu_report_t alu_report,
    input  fu_pkg::fu_report_t lsu_report,

    output logic               retire_valid,
    output fu_pkg::retire_t    retire_rec,
    output logic               exc_valid,
    output fu_pkg::exc_code_t  exc_code,
    output logic [31:0]        exc_pc,
    output logic [31:0]        bad_vaddr,
    output logic [15:0]        retired_count
);

    logic               flush;
    logic               disp_valid;
    uop_pkg::uop_pair_t disp_pair;
    logic               disp_ready;
    logic               commit_valid;
    fu_pkg::retire_t    commit_rec;
    logic               commit_ready;

    dispatch_stage i_dispatch_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_pair    (in_pair),
        .in_ready   (in_ready),
        .disp_valid (disp_valid),
        .disp_pair  (disp_pair),
        .disp_ready (disp_ready)
    );

    reorder_buffer i_reorder_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .disp_valid   (disp_valid),
        .disp_pair    (disp_pair),
        .disp_ready   (disp_ready),
        .alu_report   (alu_report),
        .lsu_report   (lsu_report),
        .commit_valid (commit_valid),
        .commit_rec   (commit_rec),
        .commit_ready (commit_ready)
    );

    commit_stage i_commit_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .commit_valid  (commit_valid),
        .commit_rec    (commit_rec),
        .commit_ready  (commit_ready),
        .flush         (flush),
        .retire_valid  (retire_valid),
        .retire_rec    (retire_rec),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .exc_pc        (exc_pc),
        .bad_vaddr     (bad_vaddr),
        .retired_count (retired_count)
    );

endmodule

//--- verification/rob_tb.sv
module rob_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_pairs   = 300;
    localparam int bp_pairs    = 8;
    localparam int cycle_limit = 40 * (num_pairs + bp_pairs) + 200;

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    uop_pkg::uop_pair_t in_pair;
    logic               in_ready;
    fu_pkg::fu_report_t alu_report;
    fu_pkg::fu_report_t lsu_report;
    logic               retire_valid;
    fu_pkg::retire_t    retire_rec;
    logic               exc_valid;
    fu_pkg::exc_code_t  exc_code;
    logic [31:0]        exc_pc;
    logic [31:0]        bad_vaddr;
    logic [15:0]        retired_count;

    // expected contents of every live slot, indexed like the buffer
    fu_pkg::rob_slot_t model_slot [8][2];
    // cycle in which each slot's report was issued, -1 while still busy
    int                fin_cycle [8][2];
    // tags of valid slots in program order
    uop_pkg::rob_tag_t order_q [$];
    // busy tags already written into the buffer
    uop_pkg::rob_tag_t pool [$];
    // tags of the pair sitting in the dispatch register
    uop_pkg::rob_tag_t pend_tags [$];
    logic [2:0]        next_idx;
    logic [31:0]       pc_base;
    logic              withhold;
    logic              feeding;
    logic              always_valid;
    int                model_count;
    int                errors;
    int                checks;
    int                tests_run;
    int                tests_failed;
    int                test_err0;
    int                dispatched;
    int                flushes;
    int                cycles;

    rob_top i_rob_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_pair       (in_pair),
        .in_ready      (in_ready),
        .alu_report    (alu_report),
        .lsu_report    (lsu_report),
        .retire_valid  (retire_valid),
        .retire_rec    (retire_rec),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .exc_pc        (exc_pc),
        .bad_vaddr     (bad_vaddr),
        .retired_count (retired_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run never drained", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_slot(input string name, input fu_pkg::rob_slot_t got,
                                input fu_pkg::rob_slot_t exp);
        check_field({name, ".uop"}, 64'(got.uop), 64'(exp.uop));
        check_field({name, ".branch_taken"}, 64'(got.branch_taken), 64'(exp.branch_taken));
        check_field({name, ".cause_exc"}, 64'(got.cause_exc), 64'(exp.cause_exc));
        check_field({name, ".exc_code"}, 64'(got.exc_code), 64'(exp.exc_code));
        check_field({name, ".aux"}, 64'(got.aux), 64'(exp.aux));
    endtask

    task automatic compare_retire(input fu_pkg::retire_t got, input fu_pkg::retire_t exp);
        check_field("retire_rec.slot0_retire", 64'(got.slot0_retire), 64'(exp.slot0_retire));
        check_field("retire_rec.slot1_retire", 64'(got.slot1_retire), 64'(exp.slot1_retire));
        if (exp.slot0_retire) begin
            compare_slot("retire_rec.slot0", got.slot0, exp.slot0);
        end
        if (exp.slot1_retire) begin
            compare_slot("retire_rec.slot1", got.slot1, exp.slot1);
        end
    endtask

    task automatic compare_exc(input logic got_valid, input fu_pkg::exc_code_t got_code,
                               input logic [31:0] got_pc, input logic [31:0] got_vaddr,
                               input logic exp_valid, input fu_pkg::exc_code_t exp_code,
                               input logic [31:0] exp_pc, input logic [31:0] exp_vaddr);
        check_field("exc_valid", 64'(got_valid), 64'(exp_valid));
        if (exp_valid && got_valid) begin
            check_field("exc_code", 64'(got_code), 64'(exp_code));
            check_field("exc_pc", 64'(got_pc), 64'(exp_pc));
            check_field("bad_vaddr", 64'(got_vaddr), 64'(exp_vaddr));
        end
    endtask

    task automatic compare_count(input logic [15:0] got, input logic [15:0] exp);
        check_field("retired_count", 64'(got), 64'(exp));
    endtask

    function automatic fu_pkg::exc_code_t pick_exc();
        case ($urandom_range(4))
            0: return fu_pkg::exc_adel;
            1: return fu_pkg::exc_ades;
            2: return fu_pkg::exc_sys;
            3: return fu_pkg::exc_bp;
            default: return fu_pkg::exc_ov;
        endcase
    endfunction

    function automatic uop_pkg::uop_pair_t random_pair(input logic force_valid);
        uop_pkg::uop_pair_t p;
        p = '0;
        p.slot0.valid = force_valid || ($urandom_range(7) != 0);
        p.slot0.pc    = pc_base;
        p.slot0.dest  = 5'($urandom);
        p.slot1.valid = $urandom_range(3) != 0;
        p.slot1.pc    = pc_base + 32'd4;
        p.slot1.dest  = 5'($urandom);
        // a delay slot only makes sense behind a valid op
        p.slot1.is_delay_slot = p.slot1.valid && ($urandom_range(2) == 0);
        pc_base = pc_base + 32'd8;
        return p;
    endfunction

    // plays one functional unit for one cycle
    task automatic make_report(input logic lsu, output fu_pkg::fu_report_t r);
        int                k;
        uop_pkg::rob_tag_t t;
        logic [2:0]        idx;
        r = '0;
        if (pool.size() == 0 || $urandom_range(1) == 0) begin
            return;
        end
        k   = $urandom_range(pool.size() - 1);
        t   = pool[k];
        idx = t[3:1];
        pool.delete(k);
        r.finish = 1'b1;
        r.tag    = t;
        fin_cycle[idx][t[0]] = cycles;
        if (!lsu && $urandom_range(1) == 1) begin
            r.set_branch             = 1'b1;
            r.branch_taken           = 1'($urandom_range(1));
            r.aux.branch_target      = $urandom;
            model_slot[idx][t[0]].branch_taken = r.branch_taken;
            model_slot[idx][t[0]].aux          = r.aux;
        end else if (lsu && $urandom_range(23) == 0) begin
            r.set_exception     = 1'b1;
            r.exc_code          = pick_exc();
            r.aux.bad_vaddr     = $urandom;
            model_slot[idx][t[0]].cause_exc = 1'b1;
            model_slot[idx][t[0]].exc_code  = r.exc_code;
            model_slot[idx][t[0]].aux       = r.aux;
        end
    endtask

    task automatic accept_pair(input uop_pkg::uop_pair_t p);
        uop_pkg::uop_t u;
        // empty bundles never get a tag
        if (!p.slot0.valid && !p.slot1.valid) begin
            return;
        end
        for (int s = 0; s < 2; s++) begin
            u = (s == 0) ? p.slot0 : p.slot1;
            if (u.valid) begin
                model_slot[next_idx][s]     = '0;
                model_slot[next_idx][s].uop = u;
                fin_cycle[next_idx][s]      = -1;
                order_q.push_back({next_idx, 1'(s)});
                pend_tags.push_back({next_idx, 1'(s)});
            end
        end
        next_idx = next_idx + 3'd1;
        dispatched++;
    endtask

    task automatic check_outputs(output logic exp_flush);
        fu_pkg::retire_t   exp;
        fu_pkg::rob_slot_t ex;
        uop_pkg::rob_tag_t t;
        exp       = '0;
        exp_flush = 1'b0;
        ex        = '0;
        if (retire_valid && order_q.size() == 0) begin
            errors++;
            $display("retirement at %0t with no micro-op outstanding", $time);
        end else if (retire_valid) begin
            t = order_q.pop_front();
            if (t[0] == 1'b0) begin
                exp.slot0_retire = 1'b1;
                exp.slot0        = model_slot[t[3:1]][0];
                if (order_q.size() > 0 && order_q[0][3:1] == t[3:1]) begin
                    // a delay slot must leave together with its branch
                    if (exp.slot0.cause_exc) begin
                        exp.slot1_retire = 1'b0;
                    end else if (model_slot[t[3:1]][1].uop.is_delay_slot) begin
                        exp.slot1_retire = 1'b1;
                    end else begin
                        // busy clears two edges after the report is issued
                        // and reaches the commit decision one edge later
                        exp.slot1_retire = fin_cycle[t[3:1]][1] >= 0 &&
                                           fin_cycle[t[3:1]][1] <= cycles - 3;
                    end
                    if (exp.slot1_retire) begin
                        exp.slot1 = model_slot[t[3:1]][1];
                        void'(order_q.pop_front());
                    end
                end
            end else begin
                exp.slot1_retire = 1'b1;
                exp.slot1        = model_slot[t[3:1]][1];
            end
            compare_retire(retire_rec, exp);
            model_count += int'(exp.slot0_retire) + int'(exp.slot1_retire);
            exp_flush = (exp.slot0_retire && exp.slot0.cause_exc) ||
                        (exp.slot1_retire && exp.slot1.cause_exc);
            ex = (exp.slot0_retire && exp.slot0.cause_exc) ? exp.slot0 : exp.slot1;
        end
        compare_exc(exc_valid, exc_code, exc_pc, bad_vaddr,
                    exp_flush, ex.exc_code, ex.uop.pc, ex.aux.bad_vaddr);
    endtask

    // one clock of model and stimulus; outputs are read on the falling edge
    task automatic step();
        fu_pkg::fu_report_t alu_r;
        fu_pkg::fu_report_t lsu_r;
        uop_pkg::uop_pair_t np;
        logic               nv;
        logic               accepted;
        logic               exp_flush;
        @(negedge clk);
        check_outputs(exp_flush);
        if (exp_flush) begin
            order_q.delete();
            pool.delete();
            pend_tags.delete();
            next_idx = '0;
            flushes++;
        end
        alu_r = '0;
        lsu_r = '0;
        if (!withhold) begin
            make_report(1'b0, alu_r);
            make_report(1'b1, lsu_r);
        end
        accepted = in_valid && in_ready;
        // ready high means the held pair moves into the buffer this edge
        if (in_ready) begin
            foreach (pend_tags[i]) begin
                pool.push_back(pend_tags[i]);
            end
            pend_tags.delete();
        end
        if (accepted) begin
            accept_pair(in_pair);
        end
        nv = in_valid;
        np = in_pair;
        if (!in_valid || accepted) begin
            nv = feeding && (always_valid || $urandom_range(3) != 0);
            np = random_pair(always_valid);
        end
        @(posedge clk);
        in_valid   <= nv;
        in_pair    <= np;
        alu_report <= alu_r;
        lsu_report <= lsu_r;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
        end
        $display("test %-14s %0d errors  (pairs %0d, flushes %0d, retired %0d)",
                 name, errors - test_err0, dispatched, flushes, model_count);
        test_err0 = errors;
    endtask

    initial begin
        void'($urandom(32'hbcf4_4202));
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_pair    = '0;
        alu_report = '0;
        lsu_report = '0;
        pc_base    = 32'h0040_0000;
        next_idx   = '0;
        withhold   = 1'b1;
        feeding    = 1'b1;
        always_valid = 1'b1;
        model_count  = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_err0    = 0;
        dispatched   = 0;
        flushes      = 0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        check_field("in_ready", 64'(in_ready), 64'd1);
        check_field("retire_valid", 64'(retire_valid), 64'd0);
        check_field("exc_valid", 64'(exc_valid), 64'd0);
        compare_count(retired_count, 16'd0);
        end_test("reset");

        // with the units silent the buffer and the register fill up
        repeat (20) step();
        check_field("in_ready", 64'(in_ready), 64'd0);
        if (dispatched != bp_pairs) begin
            errors++;
            $display("back-pressure let %0d pairs in, expected %0d", dispatched, bp_pairs);
        end
        end_test("backpressure");

        withhold     = 1'b0;
        always_valid = 1'b0;
        while (dispatched < num_pairs + bp_pairs) begin
            step();
        end
        feeding = 1'b0;
        while (order_q.size() != 0 || in_valid) begin
            step();
        end
        repeat (4) step();
        end_test("retire_order");

        compare_count(retired_count, 16'(model_count));
        end_test("count");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/uop_pkg.sv
logic/fu_pkg.sv
logic/dispatch_stage.sv
logic/reorder_buffer.sv
logic/commit_stage.sv
logic/rob_top.sv
verification/rob_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := rob_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
